/* wb_retire.f */
+incdir+common
common/wb_pkg.sv
writeback/wb_control.sv
writeback/wb_decode.sv
writeback/wb_datapath.sv
source/reg_file.sv
source/wb_top.sv
tests/wb_tb.sv

/* Bender.yml */
package:
  name: wb_retire

sources:
  - include_dirs:
      - common
    files:
      - common/wb_pkg.sv
      - writeback/wb_control.sv
      - writeback/wb_decode.sv
      - writeback/wb_datapath.sv
      - source/reg_file.sv
      - source/wb_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/wb_tb.sv

/* tests/wb_tb.sv */
`timescale 1ns/1ps
`include "wb_config.svh"

module wb_tb;
    import wb_pkg::*;

    logic      clk;
    logic      rst;
    logic      mem_done_i;
    mem_rec_t  mem_rec_i;
    reg_addr_t rs_addr_i;
    word_t     rs_data_o;
    logic      wb_active_o;
    logic      pc_wen_o;

    logic [31:0] lcg_state;
    word_t       model_regs [32];

    wb_top dut (
        .clk         (clk),
        .rst         (rst),
        .mem_done_i  (mem_done_i),
        .mem_rec_i   (mem_rec_i),
        .rs_addr_i   (rs_addr_i),
        .rs_data_o   (rs_data_o),
        .wb_active_o (wb_active_o),
        .pc_wen_o    (pc_wen_o)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Ten major opcodes, one unknown, and extra weight on loads
    function automatic logic [6:0] pick_opcode(input logic [3:0] idx);
        case (idx)
            4'd0:    return `WB_OP_LUI;
            4'd1:    return `WB_OP_AUIPC;
            4'd2:    return `WB_OP_JAL;
            4'd3:    return `WB_OP_JALR;
            4'd4:    return `WB_OP_BRANCH;
            4'd5:    return `WB_OP_STORE;
            4'd6:    return `WB_OP_IMM;
            4'd7:    return `WB_OP_REG;
            4'd8:    return `WB_OP_SYSTEM;
            4'd9:    return 7'b1111111;
            default: return `WB_OP_LOAD;
        endcase
    endfunction

    function automatic mem_rec_t make_record();
        mem_rec_t    rec;
        logic [31:0] r;
        logic [31:0] upper;
        reg_addr_t   rd;
        r = next_rand();
        upper = next_rand();
        // Roughly one in eight records targets x0
        rd = (r[31:29] == 3'd0) ? 5'd0 : r[27:23];
        rec.inst = {upper[31:15], r[22:20], rd, pick_opcode(r[19:16])};
        rec.pc = next_rand();
        rec.result = next_rand();
        rec.load_word = next_rand();
        return rec;
    endfunction

    function automatic logic model_writes(input word_t inst);
        case (inst[6:0])
            `WB_OP_LUI, `WB_OP_AUIPC, `WB_OP_IMM, `WB_OP_REG: return 1'b1;
            `WB_OP_LOAD, `WB_OP_JAL, `WB_OP_JALR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic word_t load_value(input mem_rec_t rec);
        word_t       shifted;
        word_t       half_shifted;
        logic [7:0]  b;
        logic [15:0] h;
        shifted = rec.load_word >> (8 * rec.result[1:0]);
        half_shifted = rec.load_word >> (16 * rec.result[1]);
        b = shifted[7:0];
        h = half_shifted[15:0];
        case (rec.inst[14:12])
            `WB_F3_LB:  return {{24{b[7]}}, b};
            `WB_F3_LH:  return {{16{h[15]}}, h};
            `WB_F3_LBU: return {24'd0, b};
            `WB_F3_LHU: return {16'd0, h};
            default:    return rec.load_word;
        endcase
    endfunction

    function automatic word_t model_data(input mem_rec_t rec);
        case (rec.inst[6:0])
            `WB_OP_JAL, `WB_OP_JALR: return rec.pc + 32'd4;
            `WB_OP_LOAD: return load_value(rec);
            default: return rec.result;
        endcase
    endfunction

    task automatic check_value(input string name, input word_t exp, input word_t got);
        assert (got === exp) else begin
            $display("** Error: %s expected 0x%08h, got 0x%08h", name, exp, got);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic read_reg_check(input reg_addr_t addr);
        @(negedge clk);
        rs_addr_i = addr;
        #1;
        check_value($sformatf("rs_data_o (x%0d)", addr), model_regs[addr], rs_data_o);
    endtask

    task automatic sweep_all();
        for (int i = 0; i < 32; i++) begin
            read_reg_check(i[4:0]);
        end
    endtask

    task automatic retire_one();
        mem_rec_t    rec;
        int          cyc;
        logic        done;
        logic [31:0] r;
        rec = make_record();
        @(negedge clk);
        check_value("wb_active_o", 32'd0, wb_active_o);
        check_value("pc_wen_o", 32'd0, pc_wen_o);
        mem_done_i = 1'b1;
        mem_rec_i = rec;
        cyc = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            cyc++;
            mem_done_i = 1'b0;
            // Active in the cycle after capture, PC strobe one cycle later
            check_value("wb_active_o", (cyc == 1), wb_active_o);
            check_value("pc_wen_o", (cyc == 2), pc_wen_o);
            if (pc_wen_o) begin
                done = 1'b1;
            end else if (cyc >= 10) begin
                $display("Timed out waiting for pc_wen_o after a strobe");
                $display("STATUS: FAIL");
                $fatal(1);
            end
        end
        if (model_writes(rec.inst) && rec.inst[11:7] != 5'd0) begin
            model_regs[rec.inst[11:7]] = model_data(rec);
        end
        read_reg_check(rec.inst[11:7]);
        // Back in idle right after the PC strobe
        check_value("wb_active_o", 32'd0, wb_active_o);
        check_value("pc_wen_o", 32'd0, pc_wen_o);
        r = next_rand();
        read_reg_check(r[31:27]);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        mem_done_i = 1'b0;
        mem_rec_i = '0;
        rs_addr_i = '0;
        lcg_state = 32'hc122_2f55;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        @(negedge clk);
        check_value("wb_active_o", 32'd0, wb_active_o);
        check_value("pc_wen_o", 32'd0, pc_wen_o);
        sweep_all();

        for (int n = 0; n < 300; n++) begin
            retire_one();
        end

        sweep_all();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* source/wb_top.sv */
`timescale 1ns/1ps

module wb_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_done_i,
    input  wb_pkg::mem_rec_t  mem_rec_i,
    input  wb_pkg::reg_addr_t rs_addr_i,
    output wb_pkg::word_t     rs_data_o,
    output logic              wb_active_o,
    output logic              pc_wen_o
);
    import wb_pkg::*;

    logic     cap_en;
    logic     rf_we;
    word_t    inst;
    wb_ctrl_t ctrl;
    rf_wr_t   rf_wr;

    wb_control control_u (
        .clk         (clk),
        .rst         (rst),
        .mem_done_i  (mem_done_i),
        .writes_rd_i (ctrl.writes_rd),
        .cap_en_o    (cap_en),
        .rf_we_o     (rf_we),
        .wb_active_o (wb_active_o),
        .pc_wen_o    (pc_wen_o)
    );

    // Decodes the captured instruction, not the incoming one
    wb_decode decode_u (
        .inst_i (inst),
        .ctrl_o (ctrl)
    );

    wb_datapath datapath_u (
        .clk       (clk),
        .rst       (rst),
        .cap_en_i  (cap_en),
        .mem_rec_i (mem_rec_i),
        .ctrl_i    (ctrl),
        .rf_we_i   (rf_we),
        .inst_o    (inst),
        .rf_wr_o   (rf_wr)
    );

    reg_file reg_file_u (
        .clk       (clk),
        .rst       (rst),
        .wr_i      (rf_wr),
        .rs_addr_i (rs_addr_i),
        .rs_data_o (rs_data_o)
    );

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps
`include "wb_config.svh"

module reg_file (
    input  logic              clk,
    input  logic              rst,
    input  wb_pkg::rf_wr_t    wr_i,
    input  wb_pkg::reg_addr_t rs_addr_i,
    output wb_pkg::word_t     rs_data_o
);
    import wb_pkg::*;

    word_t regs [`WB_NREGS];
    logic  wr_hit;

    // x0 is never stored
    assign wr_hit = wr_i.we && (wr_i.addr != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `WB_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_hit) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    assign rs_data_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];

endmodule

/* writeback/wb_datapath.sv */
`timescale 1ns/1ps
`include "wb_config.svh"

module wb_datapath (
    input  logic              clk,
    input  logic              rst,
    input  logic              cap_en_i,
    input  wb_pkg::mem_rec_t  mem_rec_i,
    input  wb_pkg::wb_ctrl_t  ctrl_i,
    input  logic              rf_we_i,
    output wb_pkg::word_t     inst_o,
    output wb_pkg::rf_wr_t    rf_wr_o
);
    import wb_pkg::*;

    mem_rec_t   rec_q;
    word_t      link_addr;
    logic [1:0] byte_off;
    logic [7:0] load_byte;
    logic [15:0] load_half;
    word_t      load_data;
    word_t      wb_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rec_q.pc        <= `WB_RESET_PC;
            rec_q.inst      <= `WB_RESET_PC;
            rec_q.result    <= `WB_RESET_PC;
            rec_q.load_word <= `WB_RESET_PC;
        end else if (cap_en_i) begin
            rec_q <= mem_rec_i;
        end
    end

    assign inst_o = rec_q.inst;

    assign link_addr = rec_q.pc + `WB_PC_STEP;

    // Byte address of a load sits in result
    assign byte_off = rec_q.result[1:0];

    always_comb begin
        case (byte_off)
            2'd0:    load_byte = rec_q.load_word[7:0];
            2'd1:    load_byte = rec_q.load_word[15:8];
            2'd2:    load_byte = rec_q.load_word[23:16];
            default: load_byte = rec_q.load_word[31:24];
        endcase
    end

    assign load_half = byte_off[1] ? rec_q.load_word[31:16] : rec_q.load_word[15:0];

    always_comb begin
        case (ctrl_i.load_f3)
            `WB_F3_LB: begin
                load_data = {{24{load_byte[7]}}, load_byte};
            end
            `WB_F3_LH: begin
                load_data = {{16{load_half[15]}}, load_half};
            end
            `WB_F3_LBU: begin
                load_data = {24'd0, load_byte};
            end
            `WB_F3_LHU: begin
                load_data = {16'd0, load_half};
            end
            `WB_F3_LW: begin
                load_data = rec_q.load_word;
            end
            // Unknown widths fall back to the full word
            default: begin
                load_data = rec_q.load_word;
            end
        endcase
    end

    always_comb begin
        case (ctrl_i.src)
            WB_LINK: wb_data = link_addr;
            WB_ALU:  wb_data = rec_q.result;
            WB_LOAD: wb_data = load_data;
            default: wb_data = '0;
        endcase
    end

    assign rf_wr_o.we   = rf_we_i;
    assign rf_wr_o.addr = ctrl_i.rd;
    assign rf_wr_o.data = wb_data;

endmodule

/* writeback/wb_decode.sv */
`timescale 1ns/1ps
`include "wb_config.svh"

module wb_decode (
    input  wb_pkg::word_t    inst_i,
    output wb_pkg::wb_ctrl_t ctrl_o
);
    import wb_pkg::*;

    logic [6:0] opcode;
    logic       writes_rd;
    wb_src_t    src;

    assign opcode = inst_i[6:0];

    always_comb begin
        writes_rd = 1'b0;
        src       = WB_NONE;
        case (opcode)
            `WB_OP_LUI,
            `WB_OP_AUIPC,
            `WB_OP_IMM,
            `WB_OP_REG: begin
                writes_rd = 1'b1;
                src       = WB_ALU;
            end
            `WB_OP_LOAD: begin
                writes_rd = 1'b1;
                src       = WB_LOAD;
            end
            `WB_OP_JAL,
            `WB_OP_JALR: begin
                writes_rd = 1'b1;
                src       = WB_LINK;
            end
            // Retire without touching the register file
            `WB_OP_STORE,
            `WB_OP_BRANCH,
            `WB_OP_SYSTEM: begin
                writes_rd = 1'b0;
                src       = WB_NONE;
            end
            default: begin
                writes_rd = 1'b0;
                src       = WB_NONE;
            end
        endcase
    end

    // rd and funct3 come straight from the instruction fields
    assign ctrl_o.writes_rd = writes_rd;
    assign ctrl_o.src       = src;
    assign ctrl_o.rd        = inst_i[11:7];
    assign ctrl_o.load_f3   = inst_i[14:12];

endmodule

/* writeback/wb_control.sv */
`timescale 1ns/1ps

module wb_control (
    input  logic clk,
    input  logic rst,
    input  logic mem_done_i,
    input  logic writes_rd_i,
    output logic cap_en_o,
    output logic rf_we_o,
    output logic wb_active_o,
    output logic pc_wen_o
);
    import wb_pkg::*;

    wb_state_t state_q;
    wb_state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (mem_done_i) begin
                    state_d = ST_WB;
                end
            end
            ST_WB: begin
                state_d = ST_DONE;
            end
            ST_DONE: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Strobes outside idle are dropped here
    assign cap_en_o = mem_done_i && (state_q == ST_IDLE);

    assign wb_active_o = (state_q == ST_WB);
    assign pc_wen_o    = (state_q == ST_DONE);

    // Write only in the cycle after capture
    assign rf_we_o = writes_rd_i && (state_q == ST_WB);

    // Memory stage must not strobe while busy
    a_strobe_idle: assert property (
        @(posedge clk) disable iff (rst)
        mem_done_i |-> state_q == ST_IDLE
    ) else $error("mem_done_i asserted while writeback busy");

    a_pc_after_wb: assert property (
        @(posedge clk) disable iff (rst)
        pc_wen_o == $past(wb_active_o)
    ) else $error("pc_wen_o did not follow wb_active_o");

    // A register write always belongs to the record captured one cycle earlier
    a_we_after_cap: assert property (
        @(posedge clk) disable iff (rst)
        rf_we_o |-> $past(cap_en_o)
    ) else $error("rf_we_o without a preceding capture");

endmodule

/* common/wb_pkg.sv */
`include "wb_config.svh"

package wb_pkg;

    typedef logic [`WB_XLEN-1:0]          word_t;
    typedef logic [$clog2(`WB_NREGS)-1:0] reg_addr_t;
    typedef logic [2:0]                   funct3_t;

    // Encoding follows the old writeback mux keys
    typedef enum logic [1:0] {
        WB_NONE = 2'b00,
        WB_LINK = 2'b01,
        WB_ALU  = 2'b10,
        WB_LOAD = 2'b11
    } wb_src_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_WB   = 2'b01,
        ST_DONE = 2'b10
    } wb_state_t;

    // Record handed over by the memory stage
    typedef struct packed {
        word_t pc;
        word_t inst;
        word_t result;
        word_t load_word;
    } mem_rec_t;

    typedef struct packed {
        logic      writes_rd;
        wb_src_t   src;
        reg_addr_t rd;
        funct3_t   load_f3;
    } wb_ctrl_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } rf_wr_t;

endpackage

/* common/wb_config.svh */
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

// Datapath and register file sizing
`define WB_XLEN      32
`define WB_NREGS     32

`define WB_RESET_PC  32'h0000_0000
`define WB_PC_STEP   32'd4

// RV32I major opcodes
`define WB_OP_LUI     7'b0110111
`define WB_OP_AUIPC   7'b0010111
`define WB_OP_JAL     7'b1101111
`define WB_OP_JALR    7'b1100111
`define WB_OP_BRANCH  7'b1100011
`define WB_OP_LOAD    7'b0000011
`define WB_OP_STORE   7'b0100011
`define WB_OP_IMM     7'b0010011
`define WB_OP_REG     7'b0110011
`define WB_OP_SYSTEM  7'b1110011

// Load width codes in funct3
`define WB_F3_LB   3'b000
`define WB_F3_LH   3'b001
`define WB_F3_LW   3'b010
`define WB_F3_LBU  3'b100
`define WB_F3_LHU  3'b101

`endif
